/* files.f */
pmrq_pkg.sv
pmrq_if.sv
pmrq_dispatch.sv
pmrq_bank.sv
pmrq_wb_arbiter.sv
pmrq_top.sv
tb_pmrq_top.sv

/* Bender.yml */
package:
  name: pmrq

sources:
  - target: rtl
    files:
      - pmrq_pkg.sv
      - pmrq_if.sv
      - pmrq_dispatch.sv
      - pmrq_bank.sv
      - pmrq_wb_arbiter.sv
      - pmrq_top.sv
  - target: test
    files:
      - tb_pmrq_top.sv

/* tb_pmrq_top.sv */
// Directed tests for the default package sizes; the model expects at most one replay per cycle
`timescale 1ns/1ps

module tb_pmrq_top import pmrq_pkg::*; ();

    logic  clk_i, rstn_i, flush_i;
    logic  req_valid_i, req_store_i, replay_valid_i;
    addr_t req_addr_i, finish_addr_o;
    data_t req_data_i, replay_data_i, finish_data_o;
    tag_t  req_tag_i, replay_tag_i, finish_tag_o;
    logic  finish_valid_o, finish_store_o, full_o;

    // Reference model of the banks
    mem_req_t m_req  [PMRQ_NUM_BANKS][PMRQ_NUM_ENTRIES];
    logic     m_done [PMRQ_NUM_BANKS][PMRQ_NUM_ENTRIES];
    int       m_head [PMRQ_NUM_BANKS];
    int       m_cnt  [PMRQ_NUM_BANKS];
    int       m_last;                       // Last bank granted
    mem_req_t exp_req;
    logic     exp_valid;
    tag_t     seen_tags [$];                // Write-back tags in arrival order

    int     cycle_cnt = 0;
    int     cycle_limit = 400;              // Well above the summed test lengths
    int     errors = 0;
    int     err_start, tests_passed, tests_failed;
    string  test_name = "reset";
    integer seed = 26;

    pmrq_top i_pmrq_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Hard stop
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Model one clock, then compare the DUT write-back port
    task automatic step();
        int b;
        int slot;
        int pick;
        pick = -1;
        for (int i = 1; i <= PMRQ_NUM_BANKS; i++) begin
            b = (m_last + i) % PMRQ_NUM_BANKS;
            if (pick < 0 && m_cnt[b] != 0 && m_done[b][m_head[b]]) pick = b;
        end
        if (flush_i) begin
            pick = -1;                      // Flush beats grant and enqueue
            m_cnt  = '{default: 0};
            m_head = '{default: 0};
        end else begin
            if (replay_valid_i) begin       // Owner bank is tag mod bank count
                b = replay_tag_i % PMRQ_NUM_BANKS;
                for (int j = 0; j < m_cnt[b]; j++) begin
                    slot = (m_head[b] + j) % PMRQ_NUM_ENTRIES;
                    if (m_req[b][slot].tag == replay_tag_i) begin
                        m_done[b][slot]     = 1'b1;
                        m_req[b][slot].data = replay_data_i;
                    end
                end
            end
            if (pick >= 0) begin
                exp_req      = m_req[pick][m_head[pick]];
                m_head[pick] = (m_head[pick] + 1) % PMRQ_NUM_ENTRIES;
                m_cnt[pick]--;
                m_last = pick;
            end
            if (req_valid_i) begin
                b    = req_tag_i % PMRQ_NUM_BANKS;
                slot = (m_head[b] + m_cnt[b]) % PMRQ_NUM_ENTRIES;
                m_req[b][slot]  = '{addr: req_addr_i, data: req_data_i,
                                    tag: req_tag_i, store: req_store_i};
                m_done[b][slot] = 1'b0;
                m_cnt[b]++;
            end
        end
        exp_valid = (pick >= 0);
        @(posedge clk_i);
        #10;                                // Registered outputs settled
        check_value(test_name, exp_valid, finish_valid_o);
        if (exp_valid && finish_valid_o)
            check_value(test_name, exp_req,
                        {finish_addr_o, finish_data_o, finish_tag_o, finish_store_o});
        if (finish_valid_o) seen_tags.push_back(finish_tag_o);
    endtask

    task automatic send_req(input tag_t tag, input logic store);
        req_valid_i = 1'b1;
        req_tag_i   = tag;
        req_addr_i  = 32'h4000_0000 + 32'(tag) * 8;
        req_data_i  = {req_addr_i, ~req_addr_i};   // Overwritten by the replay
        req_store_i = store;
        step();
        req_valid_i = 1'b0;
    endtask

    task automatic send_replay(input tag_t tag, output data_t data);
        data           = {$random(seed), $random(seed)};
        replay_valid_i = 1'b1;
        replay_tag_i   = tag;
        replay_data_i  = data;
        step();
        replay_valid_i = 1'b0;
    endtask

    task automatic wait_results(input int count, input int max_cycles);
        int n;
        n = 0;
        while (seen_tags.size() < count && n < max_cycles) begin
            step();
            n++;
        end
        if (seen_tags.size() < count) begin
            $display("%s: no result appeared within %0d cycles", test_name, max_cycles);
            errors++;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            step();
            check_value(test_name, 0, finish_valid_o);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_start = errors;
        seen_tags.delete();
    endtask

    task automatic end_test();
        if (errors == err_start) tests_passed++;
        else tests_failed++;
        $display("Test %s: %s", test_name, (errors == err_start) ? "passed" : "failed");
    endtask

    task automatic test_single();
        data_t d;
        int    t0;
        begin_test("single");
        t0 = cycle_cnt;
        send_req(6'h05, 1'b1);
        send_replay(6'h05, d);
        wait_results(1, 6);
        check_value(test_name, 3, cycle_cnt - t0);      // Fastest path n+3
        check_value(test_name, {32'h4000_0028, d, 6'h05},
                    {finish_addr_o, finish_data_o, finish_tag_o});
        step();
        check_value(test_name, 0, finish_valid_o);      // Single-cycle strobe
        end_test();
    endtask

    task automatic test_in_order();
        data_t d;
        begin_test("in_order");
        send_req(6'h02, 1'b0);
        send_req(6'h06, 1'b1);
        send_req(6'h0A, 1'b0);
        send_replay(6'h0A, d);                          // Youngest first
        send_replay(6'h06, d);
        expect_quiet(3);                                // Head still waits
        send_replay(6'h02, d);
        wait_results(3, 8);
        for (int i = 0; i < seen_tags.size() && i < 3; i++)
            check_value(test_name, 6'h02 + 4 * i, seen_tags[i]);
        end_test();
    endtask

    task automatic test_round_robin();
        tag_t  exp_tags [2*PMRQ_NUM_BANKS];
        data_t d;
        int    first;
        int    bank;
        begin_test("round_robin");
        for (int b = 0; b < PMRQ_NUM_BANKS; b++) send_req(tag_t'(6'h10 + b), 1'b0);
        for (int b = 0; b < PMRQ_NUM_BANKS; b++) send_req(tag_t'(6'h14 + b), 1'b1);
        for (int b = 0; b < PMRQ_NUM_BANKS; b++) send_replay(tag_t'(6'h14 + b), d);
        expect_quiet(2);                                // Younger done, heads blocked
        first = (m_last + 1) % PMRQ_NUM_BANKS;
        for (int i = 0; i < PMRQ_NUM_BANKS; i++) begin
            bank = (first + i) % PMRQ_NUM_BANKS;
            exp_tags[i]                  = tag_t'(6'h10 + bank);  // Heads in search order
            exp_tags[i + PMRQ_NUM_BANKS] = tag_t'(6'h14 + bank);  // Then the second round
            send_replay(exp_tags[i], d);
        end
        wait_results(2 * PMRQ_NUM_BANKS, 16);
        for (int i = 0; i < seen_tags.size() && i < 2 * PMRQ_NUM_BANKS; i++)
            check_value(test_name, exp_tags[i], seen_tags[i]);
        end_test();
    endtask

    task automatic test_almost_full();
        data_t d;
        begin_test("almost_full");
        for (int i = 0; i < 4; i++) send_req(tag_t'(6'h20 + 4 * i), 1'b0);
        check_value(test_name, 0, full_o);              // Four held, still open
        send_req(6'h30, 1'b0);
        check_value(test_name, 1, full_o);              // Margin reached
        for (int i = 0; i < 5; i++) send_replay(tag_t'(6'h20 + 4 * i), d);
        wait_results(5, 8);
        check_value(test_name, 0, full_o);
        end_test();
    endtask

    task automatic test_flush();
        data_t d;
        begin_test("flush");
        send_req(6'h35, 1'b1);
        send_req(6'h39, 1'b0);
        flush_i = 1'b1;
        #1;
        check_value(test_name, 1, full_o);
        step();
        flush_i = 1'b0;
        send_replay(6'h35, d);                          // Stale tags
        send_replay(6'h39, d);
        expect_quiet(3);
        check_value(test_name, 0, seen_tags.size());
        send_req(6'h3D, 1'b1);
        send_replay(6'h3D, d);
        wait_results(1, 6);
        check_value(test_name, {6'h3D, d}, {finish_tag_o, finish_data_o});
        end_test();
    endtask

    task automatic test_unknown_tag();
        data_t d;
        begin_test("unknown_tag");
        send_req(6'h0F, 1'b0);
        send_replay(6'h0B, d);                          // Same bank, not in flight
        expect_quiet(3);
        send_replay(6'h0F, d);
        wait_results(1, 6);
        check_value(test_name, {32'h4000_0078, d, 6'h0F},
                    {finish_addr_o, finish_data_o, finish_tag_o});
        end_test();
    endtask

    initial begin
        {rstn_i, flush_i, req_valid_i, req_store_i, replay_valid_i} = '0;
        {req_addr_i, req_data_i, req_tag_i, replay_tag_i, replay_data_i} = '0;
        m_cnt  = '{default: 0};
        m_head = '{default: 0};
        m_last = PMRQ_NUM_BANKS - 1;                    // Bank 0 searched first
        repeat (2) @(posedge clk_i);
        check_value(test_name, 1, full_o);              // Stall held in reset
        #10 rstn_i = 1'b1;
        test_single();
        test_in_order();
        test_round_robin();
        test_almost_full();
        test_flush();
        test_unknown_tag();
        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* pmrq_top.sv */
// Upstream stalls on full_o and keeps tags unique; write-back has no back-pressure
`timescale 1ns/1ps

module pmrq_top import pmrq_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,          // Async, active low

    // New request
    input  logic  req_valid_i,
    input  addr_t req_addr_i,
    input  data_t req_data_i,
    input  tag_t  req_tag_i,
    input  logic  req_store_i,

    // Data arriving for a queued tag
    input  logic  replay_valid_i,
    input  tag_t  replay_tag_i,
    input  data_t replay_data_i,
    input  logic  flush_i,         // Empties every bank

    // Write-back
    output logic  finish_valid_o,
    output addr_t finish_addr_o,
    output data_t finish_data_o,
    output tag_t  finish_tag_o,
    output logic  finish_store_o,

    output logic  full_o           // Stall to issue
);

    mem_req_t req;
    mem_req_t finish_req;

    pmrq_if bank_if [PMRQ_NUM_BANKS] ();

    // Pack request fields
    assign req.addr  = req_addr_i;
    assign req.data  = req_data_i;
    assign req.tag   = req_tag_i;
    assign req.store = req_store_i;

    pmrq_dispatch i_pmrq_dispatch (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req),
        .replay_valid_i (replay_valid_i),
        .replay_tag_i   (replay_tag_i),
        .replay_data_i  (replay_data_i),
        .full_o         (full_o),
        .bank_o         (bank_if)
    );

    for (genvar g = 0; g < PMRQ_NUM_BANKS; g++) begin : g_bank
        pmrq_bank i_pmrq_bank (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .flush_i (flush_i),
            .q_io    (bank_if[g])
        );
    end

    pmrq_wb_arbiter i_pmrq_wb_arbiter (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .bank_i         (bank_if),
        .finish_valid_o (finish_valid_o),
        .finish_req_o   (finish_req)
    );

    // Unpack write-back fields
    assign finish_addr_o  = finish_req.addr;
    assign finish_data_o  = finish_req.data;
    assign finish_tag_o   = finish_req.tag;
    assign finish_store_o = finish_req.store;

endmodule

/* pmrq_wb_arbiter.sv */
// One write-back per cycle with no back-pressure; the output is registered one cycle after the pop
`timescale 1ns/1ps

module pmrq_wb_arbiter import pmrq_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,           // Async, active low
    input  logic     flush_i,          // No grant while flushing
    pmrq_if.arbiter  bank_i [PMRQ_NUM_BANKS],

    output logic     finish_valid_o,   // One-cycle write-back strobe
    output mem_req_t finish_req_o      // Write-back payload
);

    logic [PMRQ_NUM_BANKS-1:0] done_vec;
    logic [PMRQ_NUM_BANKS-1:0] pop_vec;
    mem_req_t  head_arr [PMRQ_NUM_BANKS];

    bank_idx_t last_grant;             // Search starts just after this one
    bank_idx_t grant_idx;
    logic      grant_valid;

    // Gather per-bank levels
    for (genvar g = 0; g < PMRQ_NUM_BANKS; g++) begin : g_bank
        assign done_vec[g]   = bank_i[g].head_done;
        assign head_arr[g]   = bank_i[g].head_req;
        assign pop_vec[g]    = grant_valid && (grant_idx == bank_idx_t'(g));
        assign bank_i[g].pop = pop_vec[g];
    end

    // Round-robin search
    always_comb begin : p_search
        int cand;
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int i = 1; i <= PMRQ_NUM_BANKS; i++) begin
            cand = (int'(last_grant) + i) % PMRQ_NUM_BANKS;
            if (!grant_valid && done_vec[cand]) begin
                grant_valid = !flush_i;
                grant_idx   = bank_idx_t'(cand);
            end
        end
    end

    // Pointer and strobe
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            last_grant     <= bank_idx_t'(PMRQ_NUM_BANKS - 1);  // Bank 0 first
            finish_valid_o <= 1'b0;
        end else begin
            finish_valid_o <= grant_valid;
            if (grant_valid) begin
                last_grant <= grant_idx;
            end
        end
    end

    // Payload latched from the winning head
    always_ff @(posedge clk_i) begin
        if (grant_valid) begin
            finish_req_o <= head_arr[grant_idx];
        end
    end

    a_one_pop: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(pop_vec)
    ) else $error("More than one bank popped");

endmodule

/* pmrq_bank.sv */
// In-order queue; tags must be unique while queued and a replay only hits occupied entries
`timescale 1ns/1ps

module pmrq_bank import pmrq_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,    // Async, active low
    input  logic    flush_i,   // Drops every entry
    pmrq_if.bank    q_io
);

    // Circular buffer state
    ptr_t head;                // Oldest entry
    ptr_t tail;                // Next free slot
    cnt_t count;               // Entries held

    // Per-entry control bits
    logic [PMRQ_NUM_ENTRIES-1:0] valid_q;
    logic [PMRQ_NUM_ENTRIES-1:0] done_q;

    // Request payload storage
    mem_req_t req_tbl [PMRQ_NUM_ENTRIES];

    logic enq_en;
    logic pop_en;
    logic [PMRQ_NUM_ENTRIES-1:0] rep_match;

    // Write only with a free slot; flush takes priority
    assign enq_en = q_io.enq_valid && (count < cnt_t'(PMRQ_NUM_ENTRIES)) && !flush_i;

    // Pop needs something to pop
    assign pop_en = q_io.pop && (count != '0) && !flush_i;

    // Tag compare against every occupied slot
    always_comb begin
        for (int j = 0; j < PMRQ_NUM_ENTRIES; j++) begin
            rep_match[j] = q_io.rep_valid && !flush_i && valid_q[j]
                           && (req_tbl[j].tag == q_io.rep_tag);
        end
    end

    // Pointers, occupancy and control bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else if (flush_i) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (enq_en) begin
                valid_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;   // Waits for its replay
                tail          <= tail + ptr_t'(1);
            end
            if (pop_en) begin
                valid_q[head] <= 1'b0;
                done_q[head]  <= 1'b0;
                head          <= head + ptr_t'(1);
            end
            // Replay completes the matching entry
            for (int j = 0; j < PMRQ_NUM_ENTRIES; j++) begin
                if (rep_match[j]) begin
                    done_q[j] <= 1'b1;
                end
            end
            count <= count + cnt_t'(enq_en) - cnt_t'(pop_en);
        end
    end

    // Payload table
    always_ff @(posedge clk_i) begin
        if (enq_en) begin
            req_tbl[tail] <= q_io.enq_req;
        end
        for (int j = 0; j < PMRQ_NUM_ENTRIES; j++) begin
            if (rep_match[j]) begin
                req_tbl[j].data <= q_io.rep_data;  // Patch with arriving data
            end
        end
    end

    // Head offered only once replayed, keeps program order
    assign q_io.head_done = (count != '0) && done_q[head];
    assign q_io.head_req  = req_tbl[head];

    // Early stall covers requests still in the issue pipeline
    assign q_io.almost_full = (count >= cnt_t'(PMRQ_AFULL_LEVEL)) || flush_i || !rstn_i;

    // Margin must absorb in-flight issue, so the bank never sees a request when full
    a_no_enq_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (q_io.enq_valid && !flush_i) |-> (count < cnt_t'(PMRQ_NUM_ENTRIES))
    ) else $error("Enqueue into full bank");

    // Arbiter pops only offered heads
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        q_io.pop |-> (count != '0)
    ) else $error("Pop from empty bank");

    // Unique tags in flight, never two hits
    a_single_match: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(rep_match)
    ) else $error("Replay tag matched more than one entry");

endmodule

/* pmrq_dispatch.sv */
// Purely combinational; upstream must hold req_valid_i low while full_o is high
`timescale 1ns/1ps

module pmrq_dispatch import pmrq_pkg::*; (
    input  logic    clk_i,           // Assertion sampling only
    input  logic    rstn_i,          // Assertion disable only

    input  logic     req_valid_i,    // New request strobe
    input  mem_req_t req_i,          // Request payload
    input  logic     replay_valid_i, // Replay strobe
    input  tag_t     replay_tag_i,   // Tag being completed
    input  data_t    replay_data_i,  // Arriving data

    output logic     full_o,         // Any bank near full
    pmrq_if.dispatch bank_o [PMRQ_NUM_BANKS]
);

    bank_idx_t req_bank;
    bank_idx_t rep_bank;
    logic [PMRQ_NUM_BANKS-1:0] afull_vec;

    // Bank selection from tag low bits
    assign req_bank = tag_bank(req_i.tag);
    assign rep_bank = tag_bank(replay_tag_i);

    for (genvar g = 0; g < PMRQ_NUM_BANKS; g++) begin : g_steer
        // Request decode, one bank at most
        assign bank_o[g].enq_valid = req_valid_i && (req_bank == bank_idx_t'(g));
        assign bank_o[g].enq_req   = req_i;

        // Replay goes only to the owning bank
        assign bank_o[g].rep_valid = replay_valid_i && (rep_bank == bank_idx_t'(g));
        assign bank_o[g].rep_tag   = replay_tag_i;
        assign bank_o[g].rep_data  = replay_data_i;

        assign afull_vec[g] = bank_o[g].almost_full;
    end

    // Global stall level
    assign full_o = |afull_vec;

    // Upstream honours the stall; a request under full_o could overrun a bank
    a_no_req_when_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        req_valid_i |-> !full_o
    ) else $error("Request accepted while full_o high");

    // A replay tag with X bits would steer to no defined bank
    a_rep_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        replay_valid_i |-> !$isunknown(replay_tag_i)
    ) else $error("Replay with unknown tag bits");

endmodule

/* pmrq_if.sv */
// One bank link; enq_valid and rep_valid are single-cycle strobes, pop only while head_done is high
`timescale 1ns/1ps

interface pmrq_if import pmrq_pkg::*; ();

    // Enqueue side
    logic     enq_valid;    // One request per strobe
    mem_req_t enq_req;

    // Replay side
    logic     rep_valid;    // Tag plus its arriving data
    tag_t     rep_tag;
    data_t    rep_data;

    // Head side
    logic     head_done;    // Head present and replayed
    mem_req_t head_req;
    logic     pop;          // Frees the head after the edge

    // Stall level back to the issue stage
    logic     almost_full;

    modport dispatch (
        output enq_valid, enq_req,
        output rep_valid, rep_tag, rep_data,
        input  almost_full
    );

    modport bank (
        input  enq_valid, enq_req,
        input  rep_valid, rep_tag, rep_data,
        input  pop,
        output head_done, head_req,
        output almost_full
    );

    modport arbiter (
        input  head_done, head_req,
        output pop
    );

endinterface

/* pmrq_pkg.sv */
// Sizes assume power-of-two banks and entries so that pointers and bank indices wrap naturally
package pmrq_pkg;

    // Bank split
    localparam int PMRQ_NUM_BANKS   = 4;
    localparam int PMRQ_BANK_BITS   = 2;  // Low tag bits select the bank

    // Per-bank queue geometry
    localparam int PMRQ_NUM_ENTRIES = 8;
    localparam int PMRQ_PTR_BITS    = 3;
    localparam int PMRQ_CNT_BITS    = 4;  // One above pointer width to hold a full count

    // Slots held back for requests already in the issue pipeline
    localparam int PMRQ_FULL_MARGIN = 3;

    // Payload widths
    localparam int TAG_BITS  = 6;
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 64;

    typedef logic [TAG_BITS-1:0]  tag_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;

    // Helper index types
    typedef logic [PMRQ_BANK_BITS-1:0] bank_idx_t;
    typedef logic [PMRQ_PTR_BITS-1:0]  ptr_t;
    typedef logic [PMRQ_CNT_BITS-1:0]  cnt_t;

    // One pending memory request
    typedef struct packed {
        addr_t addr;   // Target address
        data_t data;   // Store operand or load result
        tag_t  tag;    // Unique in-flight tag
        logic  store;  // 1 for store, 0 for load
    } mem_req_t;

    // Occupancy at which a bank asks upstream to stall
    localparam int PMRQ_AFULL_LEVEL = PMRQ_NUM_ENTRIES - PMRQ_FULL_MARGIN;

    // Bank that owns a tag
    function automatic bank_idx_t tag_bank(input tag_t tag);
        return tag[PMRQ_BANK_BITS-1:0];
    endfunction

endpackage
